//--- proc_config.svh
// Processor subsystem configuration
// Widths, register count and memory depths shared by the core and CSR block
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Data and instruction width
`define PROC_DATA_W 16

// General registers, r0 reads zero
`define PROC_NUM_REGS 8

// Word-addressed memories
`define PROC_IMEM_DEPTH 256
`define PROC_DMEM_DEPTH 256

// AXI4-Lite byte address width
`define PROC_AXI_ADDR_W 12

`endif

//--- procIsaPkg.sv
// ISA definitions for the single-cycle core
// Opcodes, ALU operations, decoded control bundle and field positions
`default_nettype none

package procIsaPkg;

	// Twelve defined opcodes, codes 12 to 15 are illegal
	typedef enum logic [3:0] {
		OpNop  = 4'd0,
		OpAdd  = 4'd1,
		OpSub  = 4'd2,
		OpAnd  = 4'd3,
		OpXor  = 4'd4,
		OpAddi = 4'd5,
		OpLd   = 4'd6,
		OpSt   = 4'd7,
		OpBeqz = 4'd8,
		OpBnez = 4'd9,
		OpJ    = 4'd10,
		OpHalt = 4'd11
	} opcodeE;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluXor,
		AluPassB
	} aluOpE;

	// Decoded control bundle
	typedef struct packed {
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  aluSrc;
		aluOpE aluOp;
		logic  branchZero;
		logic  branchNonZero;
		logic  jump;
		logic  halt;
		logic  illegal;
	} ctrlS;

	// Field positions, R and I formats
	localparam int OpcodeLsb = 12;
	localparam int RdLsb     = 9;
	localparam int RsLsb     = 6;
	localparam int RtLsb     = 3;
	localparam int RegFieldW = 3;
	// Branch format keeps rs in the rd slot
	localparam int BrRsLsb   = 9;
	// Immediate widths per format
	localparam int ImmIW     = 6;
	localparam int ImmBW     = 9;
	localparam int ImmJW     = 12;

endpackage

`default_nettype wire

//--- procBusPkg.sv
// AXI4-Lite channel bundles and CSR map of the processor subsystem
`default_nettype none

`include "proc_config.svh"

package procBusPkg;

	// Master to slave
	typedef struct packed {
		logic [`PROC_AXI_ADDR_W-1:0] awaddr;
		logic                        awvalid;
		logic [31:0]                 wdata;
		logic                        wvalid;
		logic                        bready;
		logic [`PROC_AXI_ADDR_W-1:0] araddr;
		logic                        arvalid;
		logic                        rready;
	} axilReqS;

	// Slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axilRspS;

	localparam logic [1:0] RespOkay   = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;

	// Register offsets
	typedef enum logic [`PROC_AXI_ADDR_W-1:0] {
		CsrCtrl    = 'h000,
		CsrStatus  = 'h004,
		CsrRetired = 'h008,
		CsrImemWr  = 'h00C,
		CsrReg0    = 'h040,
		CsrReg1    = 'h044,
		CsrReg2    = 'h048,
		CsrReg3    = 'h04C,
		CsrReg4    = 'h050,
		CsrReg5    = 'h054,
		CsrReg6    = 'h058,
		CsrReg7    = 'h05C
	} csrAddrE;

endpackage

`default_nettype wire

//--- fetch.sv
// Fetch stage
// Program counter, instruction memory with host load port, next-PC select
`timescale 1ns/10ps
`default_nettype none

`include "proc_config.svh"

module fetch (
	input  wire logic                                 clk,
	input  wire logic                                 rstN,
	input  wire logic                                 start,
	input  wire logic                                 running,
	input  wire logic                                 imemWe,
	input  wire logic [$clog2(`PROC_IMEM_DEPTH)-1:0] imemAddr,
	input  wire logic [`PROC_DATA_W-1:0]             imemData,
	input  wire logic                                 takeBranch,
	input  wire logic [`PROC_DATA_W-1:0]             target,
	output logic      [`PROC_DATA_W-1:0]             instr,
	output logic      [`PROC_DATA_W-1:0]             pcPlusOne
);

	localparam int ImemAw = $clog2(`PROC_IMEM_DEPTH);

	logic [`PROC_DATA_W-1:0] pc;
	logic [`PROC_DATA_W-1:0] imem [`PROC_IMEM_DEPTH];

	// Host load port, only used while the core is idle
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// Asynchronous read, low PC bits index the memory
	assign instr = imem[pc[ImemAw-1:0]];
	assign pcPlusOne = pc + 1'b1;

	// Start wins over the running update
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (start) begin
			pc <= '0;
		end else if (running) begin
			// Taken branch or jump, else sequential
			pc <= takeBranch ? target : pcPlusOne;
		end
	end

endmodule

`default_nettype wire

//--- decode.sv
// Decode stage
// Control decode, immediate extension, register file and write-back select
`timescale 1ns/10ps
`default_nettype none

`include "proc_config.svh"

module decode
	import procIsaPkg::*;
(
	input  wire logic                               clk,
	input  wire logic                               rstN,
	input  wire logic [`PROC_DATA_W-1:0]           instr,
	input  wire logic                               running,
	input  wire logic [`PROC_DATA_W-1:0]           loadData,
	input  wire logic [`PROC_DATA_W-1:0]           aluResult,
	input  wire logic [$clog2(`PROC_NUM_REGS)-1:0] regRdAddr,
	output ctrlS                                    ctrl,
	output logic      [`PROC_DATA_W-1:0]           rd1,
	output logic      [`PROC_DATA_W-1:0]           rd2,
	output logic      [`PROC_DATA_W-1:0]           imm,
	output logic      [`PROC_DATA_W-1:0]           regRdData
);

	localparam int W = `PROC_DATA_W;

	opcodeE                opcode;
	logic [RegFieldW-1:0]  rdAddr;
	logic [RegFieldW-1:0]  rsAddr;
	logic [RegFieldW-1:0]  rtAddr;
	logic [W-1:0]          wbData;
	logic [W-1:0]          regs [`PROC_NUM_REGS];

	assign opcode = opcodeE'(instr[OpcodeLsb +: 4]);
	assign rdAddr = instr[RdLsb +: RegFieldW];
	// Branches read their test register from the rd slot
	assign rsAddr = ctrl.branchZero || ctrl.branchNonZero ? instr[BrRsLsb +: RegFieldW]
	                                                      : instr[RsLsb +: RegFieldW];
	// ST reads its source data from the rd slot
	assign rtAddr = ctrl.memWrite ? rdAddr : instr[RtLsb +: RegFieldW];

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = AluAdd;
		imm = W'($signed(instr[ImmIW-1:0]));
		case (opcode)
			OpNop: ;
			OpAdd: ctrl.regWrite = 1'b1;
			OpSub: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = AluSub;
			end
			OpAnd: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = AluAnd;
			end
			OpXor: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = AluXor;
			end
			OpAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			// Address is rs plus offset
			OpLd: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			OpSt: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			OpBeqz, OpBnez: begin
				ctrl.branchZero = opcode == OpBeqz;
				ctrl.branchNonZero = opcode == OpBnez;
				imm = W'($signed(instr[ImmBW-1:0]));
			end
			// Absolute target, zero extended
			OpJ: begin
				ctrl.jump = 1'b1;
				imm = W'(instr[ImmJW-1:0]);
			end
			OpHalt: ctrl.halt = 1'b1;
			default: ctrl.illegal = 1'b1;
		endcase
	end

	// Three read ports, r0 forced to zero
	assign rd1 = rsAddr == '0 ? '0 : regs[rsAddr];
	assign rd2 = rtAddr == '0 ? '0 : regs[rtAddr];
	assign regRdData = regRdAddr == '0 ? '0 : regs[regRdAddr];

	// Write-back select
	assign wbData = ctrl.memToReg ? loadData : aluResult;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `PROC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (running && ctrl.regWrite && rdAddr != '0) begin
			regs[rdAddr] <= wbData;
		end
	end

endmodule

`default_nettype wire

//--- execute.sv
// Execute stage
// ALU, zero test for branches and branch or jump target
`timescale 1ns/10ps
`default_nettype none

`include "proc_config.svh"

module execute
	import procIsaPkg::*;
(
	input  ctrlS                          ctrl,
	input  wire logic [`PROC_DATA_W-1:0] rd1,
	input  wire logic [`PROC_DATA_W-1:0] rd2,
	input  wire logic [`PROC_DATA_W-1:0] imm,
	input  wire logic [`PROC_DATA_W-1:0] pcPlusOne,
	output logic      [`PROC_DATA_W-1:0] aluResult,
	output logic                          takeBranch,
	output logic      [`PROC_DATA_W-1:0] target
);

	logic [`PROC_DATA_W-1:0] opB;
	logic                    rd1Zero;

	// Second operand, immediate for ADDI, LD and ST
	assign opB = ctrl.aluSrc ? imm : rd2;

	always_comb begin
		case (ctrl.aluOp)
			AluAdd:   aluResult = rd1 + opB;
			AluSub:   aluResult = rd1 - opB;
			AluAnd:   aluResult = rd1 & opB;
			AluXor:   aluResult = rd1 ^ opB;
			AluPassB: aluResult = opB;
			default:  aluResult = '0;
		endcase
	end

	// Branch condition on the tested register
	assign rd1Zero = rd1 == '0;

	always_comb begin
		takeBranch = 1'b0;
		if (ctrl.jump) begin
			takeBranch = 1'b1;
		end else if (ctrl.branchZero) begin
			takeBranch = rd1Zero;
		end else if (ctrl.branchNonZero) begin
			takeBranch = !rd1Zero;
		end
	end

	// J is absolute, branches are relative to PC+1
	assign target = ctrl.jump ? imm : pcPlusOne + imm;

endmodule

`default_nettype wire

//--- memory.sv
// Data memory
// Synchronous write, combinational read, word addressed
`timescale 1ns/10ps
`default_nettype none

`include "proc_config.svh"

module memory (
	input  wire logic                      clk,
	input  wire logic [`PROC_DATA_W-1:0] addr,
	input  wire logic [`PROC_DATA_W-1:0] writeData,
	input  wire logic                      memWrite,
	input  wire logic                      memRead,
	output logic      [`PROC_DATA_W-1:0] readData
);

	localparam int DmemAw = $clog2(`PROC_DMEM_DEPTH);

	logic [DmemAw-1:0]       index;
	logic [`PROC_DATA_W-1:0] dmem [`PROC_DMEM_DEPTH];

	// Upper address bits ignored
	assign index = addr[DmemAw-1:0];

	// memWrite already qualified by running
	always_ff @(posedge clk) begin
		if (memWrite) begin
			dmem[index] <= writeData;
		end
	end

	// Zero when not a load
	assign readData = memRead ? dmem[index] : '0;

endmodule

`default_nettype wire

//--- procCsr.sv
// AXI4-Lite CSR block
// Run control, status, retired count, instruction load and register readback
`timescale 1ns/10ps
`default_nettype none

`include "proc_config.svh"

module procCsr
	import procBusPkg::*;
(
	input  wire logic                                 clk,
	input  wire logic                                 rstN,
	input  axilReqS                                   axilReq,
	output axilRspS                                   axilRsp,
	input  wire logic                                 retire,
	input  wire logic                                 stop,
	input  wire logic                                 illegal,
	input  wire logic [`PROC_DATA_W-1:0]             regRdData,
	output logic                                      start,
	output logic                                      running,
	output logic                                      imemWe,
	output logic      [$clog2(`PROC_IMEM_DEPTH)-1:0] imemAddr,
	output logic      [`PROC_DATA_W-1:0]             imemData,
	output logic      [$clog2(`PROC_NUM_REGS)-1:0]   regRdAddr
);

	localparam int ImemAw = $clog2(`PROC_IMEM_DEPTH);
	localparam int RegAw  = $clog2(`PROC_NUM_REGS);

	logic        awReady;
	logic        bValid;
	logic [1:0]  bResp;
	logic        arReady;
	logic        rValid;
	logic [1:0]  rResp;
	logic [31:0] rData;
	logic        wrFire;
	logic        rdFire;
	logic [1:0]  wrResp;
	logic [1:0]  rdResp;
	logic [31:0] rdMux;
	logic        halted;
	logic        err;
	logic [31:0] retired;

	// One accepted beat per ready pulse
	assign wrFire = awReady && axilReq.awvalid && axilReq.wvalid;
	assign rdFire = arReady && axilReq.arvalid;

	// Write side effects, combinational on the handshake cycle
	assign start    = wrFire && axilReq.awaddr == CsrCtrl && axilReq.wdata[0] && !running;
	assign imemWe   = wrFire && axilReq.awaddr == CsrImemWr && !running;
	assign imemAddr = axilReq.wdata[16 +: ImemAw];
	assign imemData = axilReq.wdata[`PROC_DATA_W-1:0];

	// Register index taken from the read address
	assign regRdAddr = axilReq.araddr[2 +: RegAw];

	always_comb begin
		case (axilReq.awaddr)
			CsrCtrl, CsrStatus, CsrRetired: wrResp = RespOkay;
			CsrReg0, CsrReg1, CsrReg2, CsrReg3,
			CsrReg4, CsrReg5, CsrReg6, CsrReg7: wrResp = RespOkay;
			// Instruction memory locked while running
			CsrImemWr: wrResp = running ? RespSlvErr : RespOkay;
			default: wrResp = RespSlvErr;
		endcase
	end

	always_comb begin
		rdMux = '0;
		rdResp = RespOkay;
		case (axilReq.araddr)
			CsrCtrl, CsrImemWr: rdMux = '0;
			CsrStatus: rdMux = {29'b0, running, err, halted};
			CsrRetired: rdMux = retired;
			CsrReg0, CsrReg1, CsrReg2, CsrReg3,
			CsrReg4, CsrReg5, CsrReg6, CsrReg7: rdMux = 32'(regRdData);
			default: rdResp = RespSlvErr;
		endcase
	end

	// Write channel, a held bvalid blocks the next write
	always_ff @(posedge clk) begin
		if (!rstN) begin
			awReady <= 1'b0;
			bValid <= 1'b0;
		end else begin
			awReady <= axilReq.awvalid && axilReq.wvalid && !awReady && !bValid;
			if (wrFire) begin
				bValid <= 1'b1;
			end else if (axilReq.bready) begin
				bValid <= 1'b0;
			end
		end
	end

	// Read channel, data captured on the arready cycle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			arReady <= 1'b0;
			rValid <= 1'b0;
		end else begin
			arReady <= axilReq.arvalid && !arReady && !rValid;
			if (rdFire) begin
				rValid <= 1'b1;
			end else if (axilReq.rready) begin
				rValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wrFire) begin
			bResp <= wrResp;
		end
		if (rdFire) begin
			rData <= rdMux;
			rResp <= rdResp;
		end
	end

	// Run state and retired count
	always_ff @(posedge clk) begin
		if (!rstN) begin
			running <= 1'b0;
			halted <= 1'b0;
			err <= 1'b0;
			retired <= '0;
		end else if (start) begin
			running <= 1'b1;
			halted <= 1'b0;
			err <= 1'b0;
			retired <= '0;
		end else begin
			if (retire) begin
				retired <= retired + 1'b1;
			end
			// HALT sets halted, an illegal opcode sets err
			if (stop) begin
				running <= 1'b0;
				halted <= !illegal;
				err <= illegal;
			end
		end
	end

	always_comb begin
		axilRsp.awready = awReady;
		axilRsp.wready  = awReady;
		axilRsp.bresp   = bResp;
		axilRsp.bvalid  = bValid;
		axilRsp.arready = arReady;
		axilRsp.rdata   = rData;
		axilRsp.rresp   = rResp;
		axilRsp.rvalid  = rValid;
	end

endmodule

`default_nettype wire

//--- proc.sv
// Single-cycle processor subsystem top
// CSR block over AXI4-Lite beside fetch, decode, execute and memory
`timescale 1ns/10ps
`default_nettype none

`include "proc_config.svh"

module proc
	import procIsaPkg::*;
	import procBusPkg::*;
(
	input  wire logic clk,
	input  wire logic rstN,
	input  axilReqS   axilReq,
	output axilRspS   axilRsp
);

	localparam int W = `PROC_DATA_W;

	logic                                 start;
	logic                                 running;
	logic                                 imemWe;
	logic [$clog2(`PROC_IMEM_DEPTH)-1:0] imemAddr;
	logic [W-1:0]                         imemData;
	logic [$clog2(`PROC_NUM_REGS)-1:0]   regRdAddr;
	logic [W-1:0]                         regRdData;
	logic                                 retire;
	logic                                 stop;
	logic [W-1:0]                         instr;
	logic [W-1:0]                         pcPlusOne;
	ctrlS                                 ctrl;
	logic [W-1:0]                         rd1;
	logic [W-1:0]                         rd2;
	logic [W-1:0]                         imm;
	logic [W-1:0]                         aluResult;
	logic                                 takeBranch;
	logic [W-1:0]                         target;
	logic [W-1:0]                         loadData;

	// Illegal opcodes stop the core without retiring
	assign retire = running && !ctrl.illegal;
	assign stop   = running && (ctrl.halt || ctrl.illegal);

	procCsr csr_i (.clk(clk), .rstN(rstN), .axilReq(axilReq), .axilRsp(axilRsp),
		.retire(retire), .stop(stop), .illegal(ctrl.illegal), .regRdData(regRdData),
		.start(start), .running(running), .imemWe(imemWe), .imemAddr(imemAddr),
		.imemData(imemData), .regRdAddr(regRdAddr));

	fetch fetch_i (.clk(clk), .rstN(rstN), .start(start), .running(running),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.takeBranch(takeBranch), .target(target), .instr(instr), .pcPlusOne(pcPlusOne));

	decode decode_i (.clk(clk), .rstN(rstN), .instr(instr), .running(running),
		.loadData(loadData), .aluResult(aluResult), .regRdAddr(regRdAddr), .ctrl(ctrl),
		.rd1(rd1), .rd2(rd2), .imm(imm), .regRdData(regRdData));

	execute execute_i (.ctrl(ctrl), .rd1(rd1), .rd2(rd2), .imm(imm), .pcPlusOne(pcPlusOne),
		.aluResult(aluResult), .takeBranch(takeBranch), .target(target));

	// Stores only land while running
	memory memory_i (.clk(clk), .addr(aluResult), .writeData(rd2),
		.memWrite(ctrl.memWrite && running), .memRead(ctrl.memRead), .readData(loadData));

endmodule

`default_nettype wire

//--- proc_properties.sv
// Bound assertions for the processor subsystem
// AXI4-Lite response hold and run state rules
`timescale 1ns/10ps
`default_nettype none

module procProperties
	import procBusPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input axilReqS   axilReq,
	input axilRspS   axilRsp,
	input wire logic running,
	input wire logic stop,
	input wire logic halted
);

	// B and R stay up until taken
	bHold: assert property (@(posedge clk) disable iff (!rstN)
		axilRsp.bvalid && !axilReq.bready |=> axilRsp.bvalid)
		else $error("bvalid dropped before bready");

	rHold: assert property (@(posedge clk) disable iff (!rstN)
		axilRsp.rvalid && !axilReq.rready |=> axilRsp.rvalid && $stable(axilRsp.rdata))
		else $error("rvalid or rdata changed before rready");

	runHaltExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(running && halted))
		else $error("running and halted both high");

	// Core idles right after HALT or illegal
	stopClearsRun: assert property (@(posedge clk) disable iff (!rstN)
		stop |=> !running)
		else $error("running still high after stop");

endmodule

`default_nettype wire

//--- tb_proc.sv
// Testbench for the processor subsystem
// Random programs loaded over AXI4-Lite and checked against an ISA model
`timescale 1ns/10ps
`default_nettype none

`include "proc_config.svh"

module tb_proc
	import procIsaPkg::*;
	import procBusPkg::*;
();

	localparam int W = `PROC_DATA_W;
	localparam int NumProgs = 20;
	localparam int MaxLen = 60;
	// Loads, execution, readback and polling per program, doubled
	localparam int TimeoutCycles = NumProgs * (MaxLen * 4 + MaxLen + 40 + 64) * 2;

	logic        clk;
	logic        rstN;
	axilReqS     axilReq;
	axilRspS     axilRsp;
	int unsigned cycles = 0;

	// Current program and model state
	logic [W-1:0] prog [MaxLen];
	int           progLen;
	logic [W-1:0] mRegs [`PROC_NUM_REGS];
	logic [W-1:0] mDmem [`PROC_DMEM_DEPTH];
	int           mRetired;
	logic         mHalted;
	logic         mErr;

	proc dut_i (.clk(clk), .rstN(rstN), .axilReq(axilReq), .axilRsp(axilRsp));

	bind proc procProperties props_i (.clk(clk), .rstN(rstN), .axilReq(axilReq),
		.axilRsp(axilRsp), .running(running), .stop(stop), .halted(csr_i.halted));

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("Run timed out after %0d cycles without finishing", cycles);
			$display("Finished with errors");
			$fatal(1, "Timeout");
		end
	end

	// Inputs change just after the edge, outputs are settled here
	task automatic step();
		@(posedge clk);
		#0.5;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "Check on %s failed", name);
		end
	endtask

	task automatic busWrite(input logic [`PROC_AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		logic done;
		axilReq.awaddr = addr;
		axilReq.wdata = data;
		axilReq.awvalid = 1'b1;
		axilReq.wvalid = 1'b1;
		while (!axilRsp.awready) begin
			step();
		end
		// Address and data accepted together
		checkValue("wready", 1'b1, axilRsp.wready);
		// Handshake lands on this edge
		step();
		axilReq.awvalid = 1'b0;
		axilReq.wvalid = 1'b0;
		done = 1'b0;
		// Random back-pressure on B
		while (!done) begin
			axilReq.bready = 1'($urandom % 2);
			if (axilRsp.bvalid && axilReq.bready) begin
				resp = axilRsp.bresp;
				done = 1'b1;
			end
			step();
		end
		axilReq.bready = 1'b0;
	endtask

	task automatic busRead(input logic [`PROC_AXI_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic done;
		axilReq.araddr = addr;
		axilReq.arvalid = 1'b1;
		while (!axilRsp.arready) begin
			step();
		end
		step();
		axilReq.arvalid = 1'b0;
		done = 1'b0;
		// Random back-pressure on R
		while (!done) begin
			axilReq.rready = 1'($urandom % 2);
			if (axilRsp.rvalid && axilReq.rready) begin
				data = axilRsp.rdata;
				resp = axilRsp.rresp;
				done = 1'b1;
			end
			step();
		end
		axilReq.rready = 1'b0;
	endtask

	// Zeroes r1 to r7 and stores r0 to 32 words around address zero
	// Store base sits in the offset field
	task automatic buildInitProgram(input int base);
		progLen = 40;
		for (int r = 1; r < `PROC_NUM_REGS; r++) begin
			prog[r - 1] = {OpAddi, 3'(r), 3'd0, 6'd0};
		end
		for (int k = 0; k < 32; k++) begin
			prog[7 + k] = {OpSt, 3'd0, 3'd0, 6'(base + k)};
		end
		prog[39] = {OpHalt, 12'h000};
	endtask

	task automatic buildProgram(input int idx);
		opcodeE       op;
		int           target;
		int           badAt;
		logic [W-1:0] word;
		progLen = 2 + $urandom % (MaxLen - 1);
		// Every fifth program gets one illegal word
		badAt = -1;
		if (idx % 5 == 4) begin
			badAt = $urandom % (progLen - 1);
		end
		for (int i = 0; i < progLen - 1; i++) begin
			word = W'($urandom);
			op = opcodeE'(4'($urandom % 11));
			word[15:12] = op;
			// Forward only, somewhere up to the HALT
			target = i + 1 + $urandom % (progLen - 1 - i);
			// Nothing jumps over the illegal word
			if (i < badAt && target > badAt) begin
				target = badAt;
			end
			// Loads use r0 as base so they hit the zeroed window
			if (op == OpLd) begin
				word[8:6] = 3'd0;
			end
			if (op == OpBeqz || op == OpBnez) begin
				word[8:0] = 9'(target - i - 1);
			end
			if (op == OpJ) begin
				word[11:0] = 12'(target);
			end
			prog[i] = word;
		end
		if (badAt >= 0) begin
			prog[badAt] = {4'(12 + $urandom % 4), 12'($urandom)};
		end
		prog[progLen - 1] = {OpHalt, 12'h000};
	endtask

	// ISA reference, runs the current program on the model state
	task automatic runModel();
		int           pc;
		opcodeE       op;
		logic [W-1:0] word;
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [W-1:0] imm6;
		logic [W-1:0] res;
		logic [2:0]   rd;
		pc = 0;
		mRetired = 0;
		mHalted = 1'b0;
		mErr = 1'b0;
		while (!mHalted && !mErr && pc < MaxLen) begin
			word = prog[pc];
			op = opcodeE'(word[15:12]);
			rd = word[11:9];
			a = mRegs[word[8:6]];
			b = mRegs[word[5:3]];
			imm6 = W'($signed(word[5:0]));
			res = '0;
			pc++;
			case (op)
				OpNop: ;
				OpAdd: res = a + b;
				OpSub: res = a - b;
				OpAnd: res = a & b;
				OpXor: res = a ^ b;
				OpAddi: res = a + imm6;
				OpLd: res = mDmem[8'(a + imm6)];
				OpSt: mDmem[8'(a + imm6)] = mRegs[rd];
				OpBeqz: if (mRegs[rd] == '0) pc = pc + int'($signed(word[8:0]));
				OpBnez: if (mRegs[rd] != '0) pc = pc + int'($signed(word[8:0]));
				OpJ: pc = int'(word[11:0]);
				OpHalt: mHalted = 1'b1;
				default: mErr = 1'b1;
			endcase
			// Illegal opcode stops without retiring
			if (!mErr) begin
				mRetired++;
			end
			if (op inside {OpAdd, OpSub, OpAnd, OpXor, OpAddi, OpLd} && rd != 3'd0) begin
				mRegs[rd] = res;
			end
		end
	endtask

	task automatic runProgram(input logic probeBus);
		logic [1:0]  resp;
		logic [31:0] data;
		for (int i = 0; i < progLen; i++) begin
			busWrite(CsrImemWr, {8'h00, 8'(i), prog[i]}, resp);
			checkValue("bresp IMEMWR", RespOkay, resp);
		end
		runModel();
		busWrite(CsrCtrl, 32'h1, resp);
		checkValue("bresp CTRL", RespOkay, resp);
		// Load port locked mid-run, HALT must survive
		if (probeBus) begin
			busWrite(CsrImemWr, {8'h00, 8'(progLen - 1), 16'h0000}, resp);
			checkValue("bresp IMEMWR running", RespSlvErr, resp);
		end
		data = 32'h4;
		while (data[2]) begin
			busRead(CsrStatus, data, resp);
			checkValue("rresp STATUS", RespOkay, resp);
		end
		checkValue("STATUS", {29'b0, 1'b0, mErr, mHalted}, data);
		busRead(CsrRetired, data, resp);
		checkValue("RETIRED", mRetired, data);
		for (int r = 0; r < `PROC_NUM_REGS; r++) begin
			busRead(12'(CsrReg0 + 4 * r), data, resp);
			checkValue($sformatf("REG%0d", r), 32'(mRegs[r]), data);
		end
	endtask

	initial begin
		logic [1:0]  resp;
		logic [31:0] data;
		void'($urandom(32'hd38b3259));
		axilReq = '0;
		rstN = 1'b0;
		for (int r = 0; r < `PROC_NUM_REGS; r++) begin
			mRegs[r] = '0;
		end
		repeat (2) @(posedge clk);
		#0.5;
		rstN = 1'b1;
		// Zero the load window, offsets 0 to 31 then -32 to -1
		buildInitProgram(0);
		runProgram(1'b0);
		buildInitProgram(-32);
		runProgram(1'b0);
		// Long NOP run keeps the core busy for the locked write
		progLen = MaxLen;
		for (int i = 0; i < MaxLen - 1; i++) begin
			prog[i] = {OpNop, 12'h000};
		end
		prog[MaxLen - 1] = {OpHalt, 12'h000};
		runProgram(1'b1);
		// Unmapped offsets
		busRead(12'h010, data, resp);
		checkValue("rresp unmapped", RespSlvErr, resp);
		busWrite(12'h020, 32'h1, resp);
		checkValue("bresp unmapped", RespSlvErr, resp);
		for (int p = 0; p < NumProgs; p++) begin
			buildProgram(p);
			runProgram(1'b0);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
procIsaPkg.sv
procBusPkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
procCsr.sv
proc.sv
proc_properties.sv
tb_proc.sv
